// ==== hdl/wb_macros.svh ====
/*
 * write buffer constants
 * queue depth, line width and the bus beats needed per line
 */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// queue entries
`define WB_DEPTH 5

// one cache line
`define WB_LINE_W 128

// 32-bit bus beats, follows from the line width
`define WB_BEATS (`WB_LINE_W / 32)

// occupancy count, must hold 0..WB_DEPTH
`define WB_CNT_W 3

`endif

// ==== hdl/wb_pkg.sv ====
/*
 * write buffer types
 * line address, the two views of a line, and one queue entry
 */
`include "wb_macros.svh"

package wb_pkg;

    // line address as seen by the cache
    typedef logic [31:0] wb_addr_t;

    // flat view for storage and forwarding,
    // beat view for the bus (beat 0 is the low word)
    typedef union packed {
        logic [`WB_LINE_W-1:0] flat;
        logic [`WB_BEATS-1:0][31:0] beat;
    } wb_line_u;

    // one dirty line, moved as a single value
    typedef struct packed {
        wb_addr_t addr;
        wb_line_u line;
    } wb_entry_t;

endpackage

// ==== hdl/wb_queue.sv ====
/*
 * write buffer queue
 * shift register of dirty lines with valid bits, push acknowledge and oldest-first pop
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_queue (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid,
    input  wb_pkg::wb_entry_t in_entry,
    output logic in_ready,
    input  logic pop,
    output wb_pkg::wb_entry_t head,
    output logic not_empty,
    output wb_pkg::wb_entry_t entries [`WB_DEPTH],
    output logic [`WB_DEPTH-1:0] valid
);
    import wb_pkg::*;

    localparam int CNT_W = `WB_CNT_W;

    wb_entry_t store [`WB_DEPTH];
    logic [CNT_W-1:0] count;
    logic [`WB_DEPTH-1:0] valid_nxt;
    logic full;
    logic push;

    assign full = (count == CNT_W'(`WB_DEPTH));
    assign not_empty = (count != '0);

    // one capture per acknowledge pulse, none while full
    assign push = in_valid && !in_ready && !full;

    // newest in slot 0, older entries move up
    always_ff @(posedge clk) begin
        if (push) begin
            store[0] <= in_entry;
            for (int i = 1; i < `WB_DEPTH; i++) begin
                store[i] <= store[i-1];
            end
        end
    end

    assign entries = store;

    // pop clears the oldest slot first, then a push shifts the bits along
    always_comb begin
        valid_nxt = valid;
        for (int i = 0; i < `WB_DEPTH; i++) begin
            if (pop && count == CNT_W'(i + 1)) begin
                valid_nxt[i] = 1'b0;
            end
        end
        if (push) begin
            valid_nxt = {valid_nxt[`WB_DEPTH-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            valid <= valid_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // acknowledge follows the capture edge by one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_ready <= 1'b0;
        end else begin
            in_ready <= push;
        end
    end

    // oldest entry sits at slot count-1
    always_comb begin
        head = '0;
        for (int i = 0; i < `WB_DEPTH; i++) begin
            if (count == CNT_W'(i + 1)) begin
                head = store[i];
            end
        end
    end

endmodule

// ==== hdl/wb_query_match.sv ====
/*
 * read-after-write forwarding
 * finds the youngest valid queue entry whose address matches the query
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_query_match (
    input  wb_pkg::wb_addr_t query_addr,
    input  wb_pkg::wb_entry_t entries [`WB_DEPTH],
    input  logic [`WB_DEPTH-1:0] valid,
    output logic query_hit,
    output wb_pkg::wb_line_u query_data
);

    // walk oldest to youngest so the lowest index hit is kept
    always_comb begin
        query_hit = 1'b0;
        query_data = '0;
        for (int i = `WB_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && entries[i].addr == query_addr) begin
                query_hit = 1'b1;
                query_data = entries[i].line;
            end
        end
    end

endmodule

// ==== hdl/wb_axi_writer.sv ====
/*
 * write buffer bus master
 * takes the bus lock, pops the oldest line and writes it as address, beats, response
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module wb_axi_writer (
    input  logic clk,
    input  logic rstn,
    input  logic not_empty,
    input  wb_pkg::wb_entry_t head,
    output logic pop,
    input  logic dma_lock,
    output logic wrt_lock,
    output wb_pkg::wb_addr_t aw_addr,
    output logic aw_valid,
    input  logic aw_ready,
    output logic [31:0] w_data,
    output logic w_valid,
    output logic w_last,
    input  logic w_ready,
    input  logic b_valid,
    output logic b_ready
);
    import wb_pkg::*;

    localparam int BEAT_W = $clog2(`WB_BEATS);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_RESP = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic [BEAT_W-1:0] beat;
    logic last_beat;
    wb_entry_t cur;

    // dma_lock only matters while idle
    assign pop = (state == ST_IDLE) && not_empty && !dma_lock;
    assign last_beat = (beat == BEAT_W'(`WB_BEATS - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (pop) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (aw_ready) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                if (w_ready && last_beat) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_RESP: begin
                if (b_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // beat index, restarts with every address phase
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat <= '0;
        end else if (state == ST_ADDR) begin
            beat <= '0;
        end else if (state == ST_DATA && w_ready) begin
            beat <= beat + 1'b1;
        end
    end

    // the popped line, held for the whole transaction
    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    // lock is up from the pop cycle until the response is taken
    assign wrt_lock = pop || (state != ST_IDLE);

    assign aw_valid = (state == ST_ADDR);
    assign aw_addr = cur.addr;

    assign w_valid = (state == ST_DATA);
    assign w_last = (state == ST_DATA) && last_beat;
    assign w_data = cur.line.beat[beat];

    assign b_ready = (state == ST_RESP);

endmodule

// ==== hdl/write_buffer.sv ====
/*
 * write buffer top
 * queue of dirty lines, read forwarding and a bus writer sharing a lock with DMA
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module write_buffer (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid,
    input  wb_pkg::wb_entry_t in_entry,
    output logic in_ready,
    input  wb_pkg::wb_addr_t query_addr,
    output logic query_hit,
    output wb_pkg::wb_line_u query_data,
    input  logic dma_lock,
    output logic wrt_lock,
    output wb_pkg::wb_addr_t aw_addr,
    output logic aw_valid,
    input  logic aw_ready,
    output logic [31:0] w_data,
    output logic w_valid,
    output logic w_last,
    input  logic w_ready,
    input  logic b_valid,
    output logic b_ready
);
    import wb_pkg::*;

    wb_entry_t q_entries [`WB_DEPTH];
    logic [`WB_DEPTH-1:0] q_valid;
    wb_entry_t q_head;
    logic q_not_empty;
    logic q_pop;

    wb_queue wb_queue_i (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_entry   (in_entry),
        .in_ready   (in_ready),
        .pop        (q_pop),
        .head       (q_head),
        .not_empty  (q_not_empty),
        .entries    (q_entries),
        .valid      (q_valid)
    );

    wb_query_match wb_query_match_i (
        .query_addr (query_addr),
        .entries    (q_entries),
        .valid      (q_valid),
        .query_hit  (query_hit),
        .query_data (query_data)
    );

    wb_axi_writer wb_axi_writer_i (
        .clk        (clk),
        .rstn       (rstn),
        .not_empty  (q_not_empty),
        .head       (q_head),
        .pop        (q_pop),
        .dma_lock   (dma_lock),
        .wrt_lock   (wrt_lock),
        .aw_addr    (aw_addr),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w_data     (w_data),
        .w_valid    (w_valid),
        .w_last     (w_last),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

endmodule

// ==== tests/wb_tb_tasks.svh ====
/*
 * write buffer test tasks
 * push driver, typed compares and the directed tests
 */
`ifndef WB_TB_TASKS_SVH
`define WB_TB_TASKS_SVH

task automatic check_addr(input string name, input wb_addr_t exp, input wb_addr_t act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

task automatic check_line(input string name, input wb_line_u exp, input wb_line_u act);
    if (act.flat !== exp.flat) begin
        value_errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp.flat, act.flat);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        value_errors++;
        $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

function automatic wb_entry_t random_entry();
    wb_entry_t e;
    e.addr = $urandom;
    for (int i = 0; i < `WB_BEATS; i++) begin
        e.line.beat[i] = $urandom;
    end
    return e;
endfunction

task automatic drive_push(input wb_entry_t e);
    in_valid = 1'b1;
    in_entry = e;
endtask

// entry joins the model only once acknowledged
task automatic wait_ack(input wb_entry_t e);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!in_ready && n < ACK_LIMIT);
    if (in_ready) begin
        exp_q.push_back(e);
    end else begin
        other_errors++;
        $display("push of line at %h was never acknowledged", e.addr);
    end
    in_valid = 1'b0;
endtask

task automatic push_line(input wb_entry_t e);
    drive_push(e);
    wait_ack(e);
endtask

task automatic check_query(input wb_addr_t addr, input logic hit, input wb_line_u line);
    query_addr = addr;
    #(CLK_PERIOD / 4);
    check_bit("query_hit", hit, query_hit);
    check_line("query_data", line, query_data);
    @(negedge clk);
endtask

// waits for every acknowledged line on the bus, then compares in push order
task automatic wait_drain();
    int n;
    wb_entry_t e;
    wb_entry_t g;
    n = 0;
    while (got_q.size() < exp_q.size() && n < exp_q.size() * 40 + 20) begin
        @(negedge clk);
        n++;
    end
    if (got_q.size() != exp_q.size()) begin
        other_errors++;
        $display("missing bus transaction, %0d of %0d lines written", got_q.size(), exp_q.size());
    end
    while (exp_q.size() > 0 && got_q.size() > 0) begin
        e = exp_q.pop_front();
        g = got_q.pop_front();
        check_addr("aw_addr", e.addr, g.addr);
        check_line("w_data", e.line, g.line);
    end
    exp_q.delete();
    got_q.delete();
    repeat (2) @(negedge clk);
endtask

task automatic reset_state_test();
    check_bit("wrt_lock", 1'b0, wrt_lock);
    check_bit("aw_valid", 1'b0, aw_valid);
    check_bit("w_valid", 1'b0, w_valid);
    check_bit("w_last", 1'b0, w_last);
    check_bit("b_ready", 1'b0, b_ready);
    check_bit("in_ready", 1'b0, in_ready);
    check_query(32'h0000_0000, 1'b0, '0);
    check_query(32'h0000_1040, 1'b0, '0);
endtask

task automatic single_drain_test();
    wb_entry_t e;
    e.addr = 32'h0000_1040;
    for (int i = 0; i < `WB_BEATS; i++) begin
        e.line.beat[i] = 32'hc0de_0100 + i;
    end
    stall_en = 1'b0;
    push_line(e);
    wait_drain();
    check_bit("wrt_lock", 1'b0, wrt_lock);
endtask

task automatic stall_order_test();
    int acks0;
    acks0 = ack_count;
    stall_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
        push_line(random_entry());
    end
    wait_drain();
    if (ack_count - acks0 != N_RAND) begin
        other_errors++;
        $display("%0d pushes gave %0d acknowledge pulses", N_RAND, ack_count - acks0);
    end
endtask

task automatic forwarding_test();
    wb_entry_t a1;
    wb_entry_t a2;
    wb_entry_t b;
    a1 = random_entry();
    a2 = random_entry();
    b = random_entry();
    a1.addr = 32'h0000_2000;
    a2.addr = 32'h0000_2000;
    b.addr = 32'h0000_3000;
    dma_lock = 1'b1;
    push_line(a1);
    push_line(a2);
    push_line(b);
    // newest write to a shared address wins
    check_query(32'h0000_2000, 1'b1, a2.line);
    check_query(32'h0000_3000, 1'b1, b.line);
    check_query(32'h0000_4000, 1'b0, '0);
    dma_lock = 1'b0;
    wait_drain();
    check_query(32'h0000_2000, 1'b0, '0);
endtask

task automatic full_lock_test();
    wb_entry_t extra;
    dma_lock = 1'b1;
    for (int i = 0; i < `WB_DEPTH; i++) begin
        push_line(random_entry());
    end
    extra = random_entry();
    drive_push(extra);
    // queue full and locked, so no capture
    repeat (8) begin
        @(negedge clk);
        check_bit("in_ready", 1'b0, in_ready);
    end
    dma_lock = 1'b0;
    wait_ack(extra);
    wait_drain();
endtask

`endif

// ==== tests/tb_write_buffer.sv ====
/*
 * write buffer testbench
 * clock, reset, bus responder with random stalls, lock monitor and directed tests
 */
`timescale 1ns/1ns
`include "wb_macros.svh"

module tb_write_buffer;
    import wb_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_STALL = 3;
    localparam int N_RAND = 8;
    // pushes over all tests: 1 + N_RAND + 3 + (WB_DEPTH + 1)
    localparam int N_PUSH = 1 + N_RAND + 3 + `WB_DEPTH + 1;
    localparam int TIMEOUT_CYCLES = N_PUSH * (`WB_BEATS + MAX_STALL * 6 + 8) + 200;
    localparam int ACK_LIMIT = 100;

    logic clk;
    logic rstn;
    logic in_valid;
    wb_entry_t in_entry;
    logic in_ready;
    wb_addr_t query_addr;
    logic query_hit;
    wb_line_u query_data;
    logic dma_lock;
    logic wrt_lock;
    wb_addr_t aw_addr;
    logic aw_valid;
    logic aw_ready;
    logic [31:0] w_data;
    logic w_valid;
    logic w_last;
    logic w_ready;
    logic b_valid;
    logic b_ready;

    // model and bus recorder
    wb_entry_t exp_q [$];
    wb_entry_t got_q [$];
    wb_entry_t rec;
    int rec_beats;

    int value_errors = 0;
    int other_errors = 0;
    int ack_count = 0;
    int cycles = 0;
    int stall_left = -1;
    bit stall_en = 1'b0;
    logic prev_aw_valid = 1'b0;
    logic prev_wrt_lock = 1'b0;

    `include "wb_tb_tasks.svh"

    write_buffer write_buffer_i (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_entry   (in_entry),
        .in_ready   (in_ready),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_data (query_data),
        .dma_lock   (dma_lock),
        .wrt_lock   (wrt_lock),
        .aw_addr    (aw_addr),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w_data     (w_data),
        .w_valid    (w_valid),
        .w_last     (w_last),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // bus responder, one random stall per phase
    always @(negedge clk) begin
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        if (rstn && (aw_valid || w_valid || b_ready)) begin
            if (stall_left < 0) begin
                stall_left = stall_en ? int'($urandom % (MAX_STALL + 1)) : 0;
            end
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
            end else begin
                stall_left = -1;
                if (aw_valid) begin
                    aw_ready = 1'b1;
                    rec.addr = aw_addr;
                    rec_beats = 0;
                end else if (w_valid) begin
                    w_ready = 1'b1;
                    check_bit("w_last", rec_beats == `WB_BEATS - 1, w_last);
                    if (rec_beats < `WB_BEATS) begin
                        rec.line.beat[rec_beats] = w_data;
                    end
                    rec_beats++;
                end else begin
                    b_valid = 1'b1;
                    if (rec_beats != `WB_BEATS) begin
                        other_errors++;
                        $display("line at %h was written with %0d beats", rec.addr, rec_beats);
                    end
                    got_q.push_back(rec);
                end
            end
        end
    end

    // lock rules and acknowledge count, sampled mid low phase
    always begin
        @(negedge clk);
        #(CLK_PERIOD / 4);
        if (rstn) begin
            if (in_ready) begin
                ack_count++;
            end
            if ((aw_valid || w_valid || b_ready) && !wrt_lock) begin
                other_errors++;
                $display("bus phase at %0t without wrt_lock", $time);
            end
            if (dma_lock && (wrt_lock || aw_valid)) begin
                other_errors++;
                $display("writer took the bus at %0t while dma_lock was held", $time);
            end
            if (aw_valid && !prev_aw_valid && !prev_wrt_lock) begin
                other_errors++;
                $display("wrt_lock did not rise before aw_valid at %0t", $time);
            end
        end
        prev_aw_valid = aw_valid;
        prev_wrt_lock = wrt_lock;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("run stopped after %0d cycles, the tests did not finish", cycles);
            $display("errors: %0d value, %0d other", value_errors, other_errors);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h2823));
        clk = 1'b0;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_entry = '0;
        query_addr = '0;
        dma_lock = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        reset_state_test();
        single_drain_test();
        stall_order_test();
        forwarding_test();
        full_lock_test();

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hdl
+incdir+tests
hdl/wb_pkg.sv
hdl/wb_queue.sv
hdl/wb_query_match.sv
hdl/wb_axi_writer.sv
hdl/write_buffer.sv
tests/tb_write_buffer.sv
